//--- galvo.f
galvo_pkg.sv
galvo_vector_mem.sv
galvo_scan_seq.sv
galvo_dac_spi.sv
galvo_top.sv
galvo_checker.sv
galvo_tb_monitor.sv
tb_galvo_top.sv

//--- Bender.yml
package:
  name: galvo

sources:
  - galvo_pkg.sv
  - galvo_vector_mem.sv
  - galvo_scan_seq.sv
  - galvo_dac_spi.sv
  - galvo_top.sv
  - target: test
    files:
      - galvo_checker.sv
      - galvo_tb_monitor.sv
      - tb_galvo_top.sv

//--- tb_galvo_top.sv
// testbench top with clock, reset, test table and watchdog
// Wishbone table load and readback, pixel stimulus, closing report
`timescale 1ns/1ps
module tb_galvo_top;

    typedef struct packed {
        logic                        man;      // manual mode
        logic                        dis;      // disable_galvo
        logic                        stray;    // extra pixel_done mid pixel
        logic [galvo_pkg::IDX_W-1:0] h_max;
        logic [galvo_pkg::IDX_W-1:0] v_max;
        logic [galvo_pkg::POS_W-1:0] h_pos;
        logic [galvo_pkg::POS_W-1:0] v_pos;
        logic [7:0]                  pixels;   // pixel_done pulses in this test
    } test_t;

    logic                   s_axi_h_aclk;
    logic                   rst_control_n;
    galvo_pkg::wb_req_t     wb_req;
    galvo_pkg::wb_rsp_t     wb_rsp;
    logic                   pixel_done;
    galvo_pkg::scan_cfg_t   cfg;
    galvo_pkg::manual_pos_t manual;
    logic                   disable_galvo;
    logic                   sclk;
    logic                   csn;
    logic                   mosi;
    logic                   galvo_spi_done;

    test_t                       tests [5];
    string                       names [5];
    logic [galvo_pkg::POS_W-1:0] h_tab [galvo_pkg::TABLE_DEPTH]; // host copy of the tables
    logic [galvo_pkg::POS_W-1:0] v_tab [galvo_pkg::TABLE_DEPTH];
    int                          mdl_h;       // model column
    int                          mdl_v;       // model row
    int                          pixel_wait;  // worst case cycles per pixel, doubled
    longint                      budget_ns;   // watchdog limit

    galvo_top        i_dut (.*);
    galvo_tb_monitor i_mon (.*);

    initial begin
        s_axi_h_aclk = 1'b0;
        forever #10 s_axi_h_aclk = ~s_axi_h_aclk; // 20 ns period
    end

    initial begin
        wait (budget_ns != 0);
        #(budget_ns);
        $display("watchdog expired after %0d ns, tests did not complete", budget_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

    // one classic cycle, request held until ack is seen
    task automatic wb_access(input logic wr, input logic [11:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        n = 0;
        @(posedge s_axi_h_aclk);
        wb_req <= {1'b1, 1'b1, wr, addr, wdata};   // cyc, stb, we, adr, dat
        do begin
            @(posedge s_axi_h_aclk);
            n++;
        end while (!wb_rsp.ack && n < 16);
        if (!wb_rsp.ack) begin
            i_mon.note_error("no Wishbone ack within 16 cycles");
        end
        rdata = wb_rsp.dat;
        wb_req <= '0;                              // drop cyc and stb
    endtask

    // expected words from the scan rules, then one pixel_done pulse
    task automatic run_pixel(input test_t t);
        logic row_end;
        int   n;
        row_end = (mdl_h == t.h_max);
        if (!t.dis) begin
            i_mon.expect_word({galvo_pkg::CODE_CH_A, (t.man ? t.h_pos : h_tab[mdl_h])});
            if (row_end || t.man) begin
                i_mon.expect_word({galvo_pkg::CODE_CH_B, (t.man ? t.v_pos : v_tab[mdl_v])});
            end
        end
        if (row_end) begin
            mdl_h = 0;
            mdl_v = (mdl_v == t.v_max) ? 0 : mdl_v + 1; // row wraps after v_max
        end else begin
            mdl_h = mdl_h + 1;
        end
        @(posedge s_axi_h_aclk);
        pixel_done <= 1'b1;
        @(posedge s_axi_h_aclk);
        pixel_done <= 1'b0;
        n = 0;
        do begin
            @(posedge s_axi_h_aclk);
            n++;
            pixel_done <= t.stray && (n == 4);     // lands in SEND_H, must be ignored
        end while (!galvo_spi_done && n < pixel_wait);
        if (!galvo_spi_done) begin
            i_mon.note_error("galvo_spi_done missing after pixel_done");
        end
    endtask

    initial begin
        longint      cycles;
        logic [31:0] hdat;
        logic [31:0] vdat;
        logic [31:0] rd;
        void'($urandom(80133));
        rst_control_n <= 1'b0;
        wb_req        <= '0;
        pixel_done    <= 1'b0;
        cfg           <= '0;
        manual        <= '0;
        disable_galvo <= 1'b0;
        mdl_h = 0;
        mdl_v = 0;
        // man dis stray, h_max, v_max, h_pos, v_pos, pixels
        tests[0] = {3'b000, 11'd3, 11'd2, 12'h000, 12'h000, 8'd14};
        tests[1] = {3'b100, 11'd3, 11'd2, 12'h5a3, 12'h0c7, 8'd4};
        tests[2] = {3'b010, 11'd4, 11'd3, 12'h000, 12'h000, 8'd6};
        tests[3] = {3'b001, 11'd4, 11'd3, 12'h000, 12'h000, 8'd5};
        tests[4] = {3'b000, 11'd9, 11'd5, 12'h000, 12'h000, 8'd25};
        names = '{"auto_small", "manual", "disabled", "stray_pulse", "auto_wide"};
        pixel_wait = 4 * (2 * galvo_pkg::WORD_W + galvo_pkg::GUARD_CYCLES + 4);
        cycles = 4 * galvo_pkg::TABLE_DEPTH * 6 + 100;   // loads and readbacks
        foreach (tests[t]) begin
            cycles += tests[t].pixels * pixel_wait;
        end
        budget_ns = cycles * 2 * 20;                     // margin of two
        repeat (2) @(posedge s_axi_h_aclk);
        rst_control_n <= 1'b1;
        @(posedge s_axi_h_aclk);
        i_mon.start_test("reset_idle");
        i_mon.check_idle();
        i_mon.finish_test(0);
        i_mon.start_test("wb_tables");
        for (int i = 0; i < galvo_pkg::TABLE_DEPTH; i++) begin
            hdat = $urandom;
            vdat = $urandom;
            h_tab[i] = hdat[galvo_pkg::POS_W-1:0];
            v_tab[i] = vdat[galvo_pkg::POS_W-1:0];
            wb_access(1'b1, {1'b0, galvo_pkg::IDX_W'(i)}, hdat, rd);
            wb_access(1'b1, {1'b1, galvo_pkg::IDX_W'(i)}, vdat, rd);
        end
        for (int i = 0; i < galvo_pkg::TABLE_DEPTH; i++) begin
            wb_access(1'b0, {1'b0, galvo_pkg::IDX_W'(i)}, '0, rd);
            i_mon.compare($sformatf("h[%0d]", i), {20'h0, h_tab[i]}, rd);
            wb_access(1'b0, {1'b1, galvo_pkg::IDX_W'(i)}, '0, rd);
            i_mon.compare($sformatf("v[%0d]", i), {20'h0, v_tab[i]}, rd);
        end
        i_mon.finish_test(0);
        foreach (tests[t]) begin
            i_mon.start_test(names[t]);
            @(posedge s_axi_h_aclk);
            cfg           <= {tests[t].man, tests[t].h_max, tests[t].v_max};
            manual        <= {tests[t].h_pos, tests[t].v_pos};
            disable_galvo <= tests[t].dis;
            repeat (tests[t].pixels) run_pixel(tests[t]);
            repeat (3) @(posedge s_axi_h_aclk);          // let the last pulse be counted
            i_mon.finish_test(tests[t].pixels);
        end
        $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
                 i_mon.tests_run, i_mon.tests_failed, i_mon.total_errs, i_dut.i_chk.fails);
        if (i_mon.total_errs == 0 && i_dut.i_chk.fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- galvo_tb_monitor.sv
// SPI word decoder and galvo_spi_done pulse counter
// compares against queued expected words, prints one line per test
`timescale 1ns/1ps
module galvo_tb_monitor (
    input logic s_axi_h_aclk,
    input logic rst_control_n,
    input logic csn,
    input logic sclk,
    input logic mosi,
    input logic galvo_spi_done
);

    logic [galvo_pkg::WORD_W-1:0] exp_q [$];   // words still to come
    logic [galvo_pkg::WORD_W-1:0] rx_word;     // shifted in from mosi
    logic  csn_q  = 1'b1;
    logic  sclk_q = 1'b0;
    int    rx_bits;
    int    words;                              // words seen this test
    int    pulses;                             // done pulses this test
    int    test_errs;
    int    total_errs;
    int    tests_run;
    int    tests_failed;
    string cur_name = "none";

    task automatic note_error(input string msg);
        $display("ERROR %s: %s", cur_name, msg);
        test_errs++;
        total_errs++;
    endtask

    task automatic compare(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("MISMATCH %s %s expected %h actual %h", cur_name, what, exp_v, act_v);
            test_errs++;
            total_errs++;
        end
    endtask

    task automatic expect_word(input logic [galvo_pkg::WORD_W-1:0] w);
        exp_q.push_back(w);
    endtask

    task automatic start_test(input string name);
        cur_name  = name;
        test_errs = 0;
        words     = 0;
        pulses    = 0;
        exp_q.delete();
    endtask

    task automatic check_idle();
        compare("csn", 32'd1, csn);
        compare("sclk", 32'd0, sclk);
        compare("mosi", 32'd1, mosi);
        compare("galvo_spi_done", 32'd0, galvo_spi_done);
    endtask

    task automatic finish_test(input int exp_pulses);
        if (pulses != exp_pulses) begin
            note_error($sformatf("%0d galvo_spi_done pulses for %0d pixels", pulses, exp_pulses));
        end
        if (exp_q.size() != 0) begin
            note_error($sformatf("%0d expected SPI words never arrived", exp_q.size()));
        end
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("test %s: %s, %0d words, %0d done pulses", cur_name,
                 (test_errs == 0) ? "ok" : "failed", words, pulses);
    endtask

    // values seen here are the ones from before this edge
    always @(posedge s_axi_h_aclk) begin
        if (rst_control_n) begin
            if (galvo_spi_done) begin
                pulses++;
            end
            if (!csn && csn_q) begin
                rx_bits = 0;                                // word starts
            end
            if (!csn && sclk && !sclk_q) begin
                rx_word = {rx_word[galvo_pkg::WORD_W-2:0], mosi}; // msb first
                rx_bits++;
            end
            if (csn && !csn_q) begin
                words++;
                if (rx_bits != galvo_pkg::WORD_W) begin
                    note_error($sformatf("SPI word ended after %0d bits", rx_bits));
                end else if (exp_q.size() == 0) begin
                    note_error($sformatf("unexpected SPI word %h", rx_word));
                end else begin
                    compare("spi word", exp_q.pop_front(), rx_word);
                end
            end
        end
        csn_q  = csn;
        sclk_q = sclk;
    end

endmodule

//--- galvo_checker.sv
// concurrent assertions on the Wishbone ack and the SPI idle rules
// bound into galvo_top
`timescale 1ns/1ps
module galvo_checker (
    input logic               s_axi_h_aclk,
    input logic               rst_control_n,
    input galvo_pkg::wb_req_t wb_req,
    input galvo_pkg::wb_rsp_t wb_rsp,
    input logic               disable_galvo,
    input logic               sclk,
    input logic               csn
);

    int fails = 0;                                 // read by the testbench top

    ack_single: assert property (@(posedge s_axi_h_aclk) disable iff (!rst_control_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin $error("Wishbone ack held for more than one cycle"); fails++; end

    // ack answers a request seen one cycle earlier
    ack_after_stb: assert property (@(posedge s_axi_h_aclk) disable iff (!rst_control_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else begin $error("Wishbone ack without cyc and stb before it"); fails++; end

    sclk_idle: assert property (@(posedge s_axi_h_aclk) disable iff (!rst_control_n)
        csn |-> !sclk)
        else begin $error("sclk high while csn is high"); fails++; end

    disable_idle: assert property (@(posedge s_axi_h_aclk) disable iff (!rst_control_n)
        disable_galvo |-> (csn && !sclk))          // pins parked while disabled
        else begin $error("SPI pins active while disable_galvo is high"); fails++; end

endmodule

bind galvo_top galvo_checker i_chk (.*);

//--- galvo_top.sv
// galvo scanner controller top level
// vector memory, scan sequencer and SPI DAC master
`timescale 1ns/1ps
module galvo_top (
    input  logic                   s_axi_h_aclk,
    input  logic                   rst_control_n,
    input  galvo_pkg::wb_req_t     wb_req,         // host table access
    output galvo_pkg::wb_rsp_t     wb_rsp,
    input  logic                   pixel_done,     // one cycle per pixel
    input  galvo_pkg::scan_cfg_t   cfg,
    input  galvo_pkg::manual_pos_t manual,
    input  logic                   disable_galvo,
    output logic                   sclk,
    output logic                   csn,
    output logic                   mosi,
    output logic                   galvo_spi_done  // pixel finished
);

    galvo_pkg::axis_e            rd_axis;          // scan read table
    logic [galvo_pkg::IDX_W-1:0] rd_idx;
    logic [galvo_pkg::POS_W-1:0] rd_pos;
    galvo_pkg::dac_word_t        dac_word;         // sequencer to spi
    logic                        word_valid;
    logic                        word_ready;
    logic                        spi_done;

    galvo_vector_mem u_mem (
        .s_axi_h_aclk  (s_axi_h_aclk),
        .rst_control_n (rst_control_n),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .rd_axis       (rd_axis),
        .rd_idx        (rd_idx),
        .rd_pos        (rd_pos)
    );

    galvo_scan_seq u_seq (
        .s_axi_h_aclk   (s_axi_h_aclk),
        .rst_control_n  (rst_control_n),
        .pixel_done     (pixel_done),
        .cfg            (cfg),
        .manual         (manual),
        .rd_axis        (rd_axis),
        .rd_idx         (rd_idx),
        .rd_pos         (rd_pos),
        .word           (dac_word),
        .word_valid     (word_valid),
        .word_ready     (word_ready),
        .spi_done       (spi_done),
        .galvo_spi_done (galvo_spi_done)
    );

    galvo_dac_spi u_spi (
        .s_axi_h_aclk  (s_axi_h_aclk),
        .rst_control_n (rst_control_n),
        .word          (dac_word),
        .word_valid    (word_valid),
        .word_ready    (word_ready),
        .spi_done      (spi_done),
        .disable_galvo (disable_galvo),
        .sclk          (sclk),
        .csn           (csn),
        .mosi          (mosi)
    );

endmodule

//--- galvo_dac_spi.sv
// 16-bit SPI shift master for the galvo DAC, MSB first
// sclk divider, bit counter and disable gating of the pins
`timescale 1ns/1ps
module galvo_dac_spi (
    input  logic                 s_axi_h_aclk,
    input  logic                 rst_control_n,
    input  galvo_pkg::dac_word_t word,
    input  logic                 word_valid,
    output logic                 word_ready,    // low while shifting
    output logic                 spi_done,      // one cycle at csn rise
    input  logic                 disable_galvo, // pins forced idle
    output logic                 sclk,
    output logic                 csn,
    output logic                 mosi
);

    logic                            busy;      // word in flight, csn low
    logic                            phase;     // sclk level, 2 cycles per bit
    logic [galvo_pkg::BIT_CNT_W-1:0] bit_cnt;   // bits sent so far
    logic [galvo_pkg::WORD_W-1:0]    shreg;     // msb drives mosi
    logic                            accept;    // handshake this cycle
    logic                            last_bit;  // final high phase

    assign word_ready = !busy;
    assign accept     = word_valid && !busy;
    assign last_bit   = phase && (bit_cnt == galvo_pkg::BIT_CNT_W'(galvo_pkg::WORD_W - 1));

    always_ff @(posedge s_axi_h_aclk or negedge rst_control_n) begin
        if (!rst_control_n) begin
            busy     <= 1'b0;
            phase    <= 1'b0;
            bit_cnt  <= '0;
            spi_done <= 1'b0;
        end else begin
            spi_done <= 1'b0;
            if (accept) begin
                busy    <= 1'b1;                   // csn falls, sclk stays low
                phase   <= 1'b0;
                bit_cnt <= '0;
            end else if (busy && !phase) begin
                phase <= 1'b1;                     // rising edge, dac samples
            end else if (busy) begin
                phase   <= 1'b0;                   // falling edge, next bit
                bit_cnt <= bit_cnt + 1'b1;
                if (last_bit) begin
                    busy     <= 1'b0;              // csn back high
                    spi_done <= 1'b1;
                end
            end
        end
    end

    // shift on the falling sclk edge so mosi moves while sclk is low
    always_ff @(posedge s_axi_h_aclk) begin
        if (accept) begin
            shreg <= word;
        end else if (busy && phase) begin
            shreg <= {shreg[galvo_pkg::WORD_W-2:0], 1'b0};
        end
    end

    // disable holds the pins idle, handshake keeps running
    assign sclk = !disable_galvo && phase;
    assign csn  = disable_galvo || !busy;
    assign mosi = (busy && !disable_galvo) ? shreg[galvo_pkg::WORD_W-1] : 1'b1; // idles high

endmodule

//--- galvo_scan_seq.sv
// raster counters and pixel sequencer FSM
// DAC word building from table or manual positions, guard timer
`timescale 1ns/1ps
module galvo_scan_seq (
    input  logic                        s_axi_h_aclk,
    input  logic                        rst_control_n,
    input  logic                        pixel_done,     // one cycle pulse
    input  galvo_pkg::scan_cfg_t        cfg,
    input  galvo_pkg::manual_pos_t      manual,
    output galvo_pkg::axis_e            rd_axis,        // scan read port
    output logic [galvo_pkg::IDX_W-1:0] rd_idx,
    input  logic [galvo_pkg::POS_W-1:0] rd_pos,
    output galvo_pkg::dac_word_t        word,           // to spi master
    output logic                        word_valid,
    input  logic                        word_ready,
    input  logic                        spi_done,       // csn went high
    output logic                        galvo_spi_done  // end of pixel
);

    galvo_pkg::scan_state_e        state_q;
    galvo_pkg::scan_state_e        state_d;

    logic [galvo_pkg::IDX_W-1:0]   h_idx;          // next column
    logic [galvo_pkg::IDX_W-1:0]   v_idx;          // current row
    logic [galvo_pkg::IDX_W-1:0]   lat_h;          // column of this pixel
    logic [galvo_pkg::IDX_W-1:0]   lat_v;          // row of this pixel
    logic                          send_v;         // vertical word pending
    logic                          lat_man;        // manual mode of this pixel
    logic                          sent;           // word accepted by spi
    logic [galvo_pkg::GUARD_W-1:0] guard_cnt;      // cycles left in gap
    logic                          row_end;        // last column reached
    logic                          pixel_take;     // pixel start
    logic                          in_send;        // SEND_H or SEND_V
    logic                          is_v;           // vertical word selected

    assign row_end    = (h_idx == cfg.h_max);
    assign pixel_take = pixel_done && (state_q == galvo_pkg::IDLE); // ignored elsewhere
    assign in_send    = (state_q == galvo_pkg::SEND_H) || (state_q == galvo_pkg::SEND_V);
    assign is_v       = (state_q == galvo_pkg::SEND_V);

    // raster counters, advance once per accepted pixel
    always_ff @(posedge s_axi_h_aclk or negedge rst_control_n) begin
        if (!rst_control_n) begin
            h_idx   <= '0;
            v_idx   <= '0;
            send_v  <= 1'b0;
            lat_man <= 1'b0;
        end else if (pixel_take) begin
            send_v  <= row_end || cfg.manual_mode; // manual sends both words
            lat_man <= cfg.manual_mode;
            h_idx   <= row_end ? '0 : h_idx + 1'b1;
            if (row_end) begin
                v_idx <= (v_idx == cfg.v_max) ? '0 : v_idx + 1'b1; // wrap after v_max
            end
        end
    end

    // pixel coordinates, held for the whole pixel
    always_ff @(posedge s_axi_h_aclk) begin
        if (pixel_take) begin
            lat_h <= h_idx;
            lat_v <= v_idx;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            galvo_pkg::IDLE: begin
                if (pixel_done) begin
                    state_d = galvo_pkg::SEND_H;
                end
            end
            galvo_pkg::SEND_H: begin
                if (sent && spi_done) begin
                    state_d = galvo_pkg::GUARD_H;  // word out, start gap
                end
            end
            galvo_pkg::GUARD_H: begin
                if (guard_cnt == '0) begin
                    state_d = send_v ? galvo_pkg::SEND_V : galvo_pkg::IDLE;
                end
            end
            galvo_pkg::SEND_V: begin
                if (sent && spi_done) begin
                    state_d = galvo_pkg::GUARD_V;
                end
            end
            galvo_pkg::GUARD_V: begin
                if (guard_cnt == '0) begin
                    state_d = galvo_pkg::IDLE;
                end
            end
            default: begin
                state_d = galvo_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge s_axi_h_aclk or negedge rst_control_n) begin
        if (!rst_control_n) begin
            state_q        <= galvo_pkg::IDLE;
            sent           <= 1'b0;
            guard_cnt      <= '0;
            galvo_spi_done <= 1'b0;
        end else begin
            state_q <= state_d;
            // pulse on the way back to IDLE
            galvo_spi_done <= (state_q != galvo_pkg::IDLE) && (state_d == galvo_pkg::IDLE);
            if (word_valid && word_ready) begin
                sent <= 1'b1;                      // handed over, wait for done
            end else if (in_send && spi_done) begin
                sent <= 1'b0;
            end
            if (in_send && spi_done) begin
                guard_cnt <= galvo_pkg::GUARD_W'(galvo_pkg::GUARD_CYCLES - 1); // gap length
            end else if (guard_cnt != '0) begin
                guard_cnt <= guard_cnt - 1'b1;
            end
        end
    end

    // read address runs one state ahead so rd_pos is ready at SEND
    always_comb begin
        if ((state_q == galvo_pkg::GUARD_H) || (state_q == galvo_pkg::SEND_V)) begin
            rd_axis = galvo_pkg::AXIS_V;           // prefetch row value
            rd_idx  = lat_v;
        end else if (state_q == galvo_pkg::SEND_H) begin
            rd_axis = galvo_pkg::AXIS_H;
            rd_idx  = lat_h;
        end else begin
            rd_axis = galvo_pkg::AXIS_H;           // sampled on the pixel_done edge
            rd_idx  = h_idx;
        end
    end

    assign word_valid = in_send && !sent;
    assign word = '{
        code:  is_v ? galvo_pkg::CODE_CH_B : galvo_pkg::CODE_CH_A,
        value: lat_man ? (is_v ? manual.v_pos : manual.h_pos) : rd_pos
    };

endmodule

//--- galvo_vector_mem.sv
// Wishbone classic slave for the host side of the position tables
// horizontal and vertical tables with a one-cycle scan read port
`timescale 1ns/1ps
module galvo_vector_mem (
    input  logic                        s_axi_h_aclk,
    input  logic                        rst_control_n,
    input  galvo_pkg::wb_req_t          wb_req,
    output galvo_pkg::wb_rsp_t          wb_rsp,
    input  galvo_pkg::axis_e            rd_axis,   // table for the scan read
    input  logic [galvo_pkg::IDX_W-1:0] rd_idx,    // scan index
    output logic [galvo_pkg::POS_W-1:0] rd_pos     // valid one cycle after rd_idx
);

    // both tables in one array, first index is the axis
    logic [galvo_pkg::POS_W-1:0] table_mem [2][galvo_pkg::TABLE_DEPTH];

    logic                        ack_q;            // wishbone ack
    logic [galvo_pkg::POS_W-1:0] host_rd_q;        // host read data
    logic                        host_req;         // new request this cycle
    galvo_pkg::axis_e            host_axis;        // table from address msb
    logic [galvo_pkg::IDX_W-1:0] host_idx;         // index from low address bits

    assign host_req  = wb_req.cyc && wb_req.stb && !ack_q; // ack high blocks a repeat
    assign host_axis = galvo_pkg::axis_e'(wb_req.adr[galvo_pkg::WB_ADR_W-1]);
    assign host_idx  = wb_req.adr[galvo_pkg::IDX_W-1:0];

    // ack rises one cycle after cyc and stb, drops after one cycle
    always_ff @(posedge s_axi_h_aclk or negedge rst_control_n) begin
        if (!rst_control_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= host_req;                     // single cycle pulse
        end
    end

    // host port, write lands on the ack edge
    always_ff @(posedge s_axi_h_aclk) begin
        if (host_req && wb_req.we) begin
            table_mem[host_axis][host_idx] <= wb_req.dat[galvo_pkg::POS_W-1:0]; // low 12 bits
        end
        if (host_req) begin
            host_rd_q <= table_mem[host_axis][host_idx]; // returned with ack
        end
    end

    // scan port reads every cycle
    always_ff @(posedge s_axi_h_aclk) begin
        rd_pos <= table_mem[rd_axis][rd_idx];      // fixed latency of one
    end

    assign wb_rsp = '{
        ack: ack_q,
        dat: {{(galvo_pkg::WB_DAT_W - galvo_pkg::POS_W){1'b0}}, host_rd_q} // zero extend
    };

endmodule

//--- galvo_pkg.sv
// widths, table sizes, guard time and DAC command codes
// sequencer state and axis enums
// Wishbone, scan config, manual position and DAC word structs
package galvo_pkg;

    localparam int POS_W        = 12;                  // dac position bits
    localparam int IDX_W        = 11;                  // table index bits
    localparam int TABLE_DEPTH  = 2048;                // entries per axis
    localparam int WORD_W       = 16;                  // spi word bits
    localparam int CODE_W       = 4;                   // dac command bits
    localparam int GUARD_CYCLES = 16;                  // idle gap after each word
    localparam int GUARD_W      = $clog2(GUARD_CYCLES); // holds GUARD_CYCLES-1
    localparam int BIT_CNT_W    = $clog2(WORD_W);      // bit index inside a word

    localparam logic [CODE_W-1:0] CODE_CH_A = 4'b0001; // load and update channel a, horizontal
    localparam logic [CODE_W-1:0] CODE_CH_B = 4'b0100; // load and update channel b, vertical

    localparam int WB_ADR_W = 12;                      // msb picks the table
    localparam int WB_DAT_W = 32;                      // only low POS_W bits stored

    // pixel sequencer states
    typedef enum logic [2:0] {
        IDLE,                                          // waiting for pixel_done
        SEND_H,                                        // horizontal word in flight
        GUARD_H,                                       // gap after horizontal word
        SEND_V,                                        // vertical word in flight
        GUARD_V                                        // gap after vertical word
    } scan_state_e;

    typedef enum logic {
        AXIS_H = 1'b0,                                 // horizontal table
        AXIS_V = 1'b1                                  // vertical table
    } axis_e;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;                      // {table, index}
        logic [WB_DAT_W-1:0] dat;                      // write data
    } wb_req_t;

    typedef struct packed {
        logic                ack;                      // one cycle per request
        logic [WB_DAT_W-1:0] dat;                      // read data, zero extended
    } wb_rsp_t;

    typedef struct packed {
        logic             manual_mode;                 // fixed positions, both words
        logic [IDX_W-1:0] h_max;                       // last column index
        logic [IDX_W-1:0] v_max;                       // last row index
    } scan_cfg_t;

    typedef struct packed {
        logic [POS_W-1:0] h_pos;                       // manual horizontal position
        logic [POS_W-1:0] v_pos;                       // manual vertical position
    } manual_pos_t;

    typedef struct packed {
        logic [CODE_W-1:0] code;                       // dac command, top bits
        logic [POS_W-1:0]  value;                      // dac position
    } dac_word_t;

endpackage
